//--- com/center_of_mass.sv
`timescale 1ns/1ps
`include "tracker_macros.svh"

module center_of_mass (
  input wire clk_65mhz,
  input wire sys_rst,
  input tracker_pkg::hcount_t hcount_in,
  input tracker_pkg::vcount_t vcount_in,
  input wire mask_in,
  input wire frame_end_in, // one cycle, arrives with the last masked pixel at most
  output tracker_pkg::hcount_t x_com,
  output tracker_pkg::vcount_t y_com,
  output logic com_valid
);

  tracker_pkg::com_state_e state;

  logic [`SUM_W-1:0] x_sum; // running sums for the current frame
  logic [`SUM_W-1:0] y_sum;
  logic [`CNT_W-1:0] pix_cnt;
  logic [`SUM_W-1:0] x_sum_next;
  logic [`SUM_W-1:0] y_sum_next;
  logic [`CNT_W-1:0] pix_cnt_next;
  logic [`SUM_W-1:0] x_sum_lat; // divider operands for the finished frame
  logic [`SUM_W-1:0] y_sum_lat;
  logic [`CNT_W-1:0] pix_cnt_lat;
  logic div_start;
  logic [`SUM_W-1:0] x_quot;
  logic [`SUM_W-1:0] y_quot;
  logic x_done;
  logic y_done;

  // the pixel seen together with frame_end still belongs to the frame
  assign x_sum_next = mask_in ? x_sum + {{(`SUM_W-`HCOUNT_W){1'b0}}, hcount_in} : x_sum;
  assign y_sum_next = mask_in ? y_sum + {{(`SUM_W-`VCOUNT_W){1'b0}}, vcount_in} : y_sum;
  assign pix_cnt_next = pix_cnt + {{(`CNT_W-1){1'b0}}, mask_in};

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      state <= tracker_pkg::com_accum;
      x_sum <= '0;
      y_sum <= '0;
      pix_cnt <= '0;
      div_start <= 1'b0;
      com_valid <= 1'b0;
      x_com <= '0;
      y_com <= '0;
    end else begin
      div_start <= 1'b0;
      com_valid <= 1'b0;
      if (frame_end_in) begin // new frame starts from zero
        x_sum <= '0;
        y_sum <= '0;
        pix_cnt <= '0;
      end else begin
        x_sum <= x_sum_next;
        y_sum <= y_sum_next;
        pix_cnt <= pix_cnt_next;
      end
      case (state)
        tracker_pkg::com_accum: begin
          if (frame_end_in && pix_cnt_next != '0) begin // empty frame keeps old center
            div_start <= 1'b1;
            state <= tracker_pkg::com_divide;
          end
        end
        tracker_pkg::com_divide: begin
          if (x_done && y_done) begin // both run in lockstep
            x_com <= x_quot[`HCOUNT_W-1:0]; // a mean never exceeds the coordinate range
            y_com <= y_quot[`VCOUNT_W-1:0];
            com_valid <= 1'b1;
            state <= tracker_pkg::com_accum;
          end
        end
        default: state <= tracker_pkg::com_accum;
      endcase
    end
  end

  // operands stay put while the dividers run
  always_ff @(posedge clk_65mhz) begin
    if (frame_end_in && state == tracker_pkg::com_accum) begin
      x_sum_lat <= x_sum_next;
      y_sum_lat <= y_sum_next;
      pix_cnt_lat <= pix_cnt_next;
    end
  end

  seq_divider x_div_i (
    .clk_65mhz(clk_65mhz),
    .sys_rst(sys_rst),
    .start(div_start),
    .dividend(x_sum_lat),
    .divisor(pix_cnt_lat),
    .quotient(x_quot),
    .busy(),
    .done(x_done)
  );

  seq_divider y_div_i (
    .clk_65mhz(clk_65mhz),
    .sys_rst(sys_rst),
    .start(div_start),
    .dividend(y_sum_lat),
    .divisor(pix_cnt_lat),
    .quotient(y_quot),
    .busy(),
    .done(y_done)
  );

  // frames must be spaced far enough apart for the divide to finish
  assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    frame_end_in |-> state == tracker_pkg::com_accum);

endmodule

//--- com/seq_divider.sv
`timescale 1ns/1ps
`include "tracker_macros.svh"

module seq_divider (
  input wire clk_65mhz,
  input wire sys_rst,
  input wire start, // one cycle pulse, operands sampled here
  input wire [`SUM_W-1:0] dividend,
  input wire [`CNT_W-1:0] divisor,
  output logic [`SUM_W-1:0] quotient,
  output logic busy,
  output logic done
);

  localparam int ITER_W = $clog2(`SUM_W);

  logic [`CNT_W-1:0] divisor_q; // held for the whole division
  logic [`CNT_W-1:0] rem_q; // partial remainder, always below the divisor
  logic [`CNT_W:0] rem_shift; // remainder with the next dividend bit shifted in
  logic [`CNT_W:0] rem_diff; // trial subtract, msb set means it went negative
  logic [ITER_W-1:0] iter_cnt; // quotient bits produced so far

  // quotient register starts as the dividend, msb feeds the remainder
  assign rem_shift = {rem_q, quotient[`SUM_W-1]};
  assign rem_diff = rem_shift - {1'b0, divisor_q};

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      busy <= 1'b0;
      done <= 1'b0;
      iter_cnt <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        iter_cnt <= '0;
      end else if (busy) begin
        iter_cnt <= iter_cnt + ITER_W'(1);
        if (iter_cnt == ITER_W'(`SUM_W - 1)) begin // last bit on this edge
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // one restoring step per cycle
  always_ff @(posedge clk_65mhz) begin
    if (start) begin
      quotient <= dividend;
      rem_q <= '0;
      divisor_q <= divisor;
    end else if (busy) begin
      if (rem_diff[`CNT_W]) begin
        rem_q <= rem_shift[`CNT_W-1:0]; // restore
        quotient <= {quotient[`SUM_W-2:0], 1'b0};
      end else begin
        rem_q <= rem_diff[`CNT_W-1:0];
        quotient <= {quotient[`SUM_W-2:0], 1'b1};
      end
    end
  end

  // the caller waits for done before the next start
  assert property (@(posedge clk_65mhz) disable iff (sys_rst) start |-> !busy);

  // fixed latency, the center of mass timing relies on it
  assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    start |-> ##(`SUM_W + 1) done);

endmodule

//--- common/tracker_macros.svh
`ifndef TRACKER_MACROS_SVH
`define TRACKER_MACROS_SVH

// screen position widths
`define HCOUNT_W 11 // up to 2047 pixels per line
`define VCOUNT_W 10 // up to 1023 lines

// center of mass arithmetic
`define SUM_W 32 // coordinate sums, also the divider dividend
`define CNT_W 20 // masked pixel count, also the divisor

// 12-bit 444 overlay colors
`define COLOR_PINK  12'hF0F // highlight for masked pixels
`define COLOR_GREEN 12'h0F0 // crosshair

`endif

//--- common/tracker_pkg.sv
`include "tracker_macros.svh"

package tracker_pkg;

  // camera pixel, 565 RGB
  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } rgb565_t;

  // output pixel, 444 RGB
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb444_t;

  typedef logic [3:0] intensity_t; // one channel, top nibble
  typedef logic [`HCOUNT_W-1:0] hcount_t;
  typedef logic [`VCOUNT_W-1:0] vcount_t;

  // code 3 is spare and falls back to red
  typedef enum logic [1:0] {ch_red = 2'd0, ch_green = 2'd1, ch_blue = 2'd2} channel_sel_e;

  typedef enum logic [1:0] {view_rgb, view_gray, view_mask, view_highlight} view_mode_e;

  typedef enum logic {com_accum, com_divide} com_state_e; // center of mass FSM

endpackage

//--- logic/channel_threshold.sv
`timescale 1ns/1ps

module channel_threshold (
  input wire clk_65mhz,
  input wire sys_rst,
  input tracker_pkg::rgb565_t pixel_in,
  input wire pixel_valid_in,
  input tracker_pkg::hcount_t hcount_in,
  input tracker_pkg::vcount_t vcount_in,
  input tracker_pkg::channel_sel_e channel_sel,
  input tracker_pkg::intensity_t lower_bound,
  input tracker_pkg::intensity_t upper_bound,
  output tracker_pkg::rgb565_t pixel_out,
  output logic valid_out,
  output tracker_pkg::hcount_t hcount_out,
  output tracker_pkg::vcount_t vcount_out,
  output tracker_pkg::intensity_t intensity_out,
  output logic mask_out
);

  tracker_pkg::intensity_t intensity; // selected channel, before the register
  logic in_band; // intensity within [lower, upper]

  // top four bits of the chosen color field
  always_comb begin
    case (channel_sel)
      tracker_pkg::ch_green: intensity = pixel_in.g[5:2];
      tracker_pkg::ch_blue:  intensity = pixel_in.b[4:1];
      default:               intensity = pixel_in.r[4:1]; // red and the spare code
    endcase
  end

  // lower above upper gives an empty band, so nothing is masked
  assign in_band = (intensity >= lower_bound) && (intensity <= upper_bound);

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      valid_out <= 1'b0;
      mask_out <= 1'b0;
    end else begin
      valid_out <= pixel_valid_in;
      mask_out <= pixel_valid_in && in_band; // idle cycles never mask
    end
  end

  // pixel and position ride along with the mask
  always_ff @(posedge clk_65mhz) begin
    pixel_out <= pixel_in;
    hcount_out <= hcount_in;
    vcount_out <= vcount_in;
    intensity_out <= intensity;
  end

endmodule

//--- logic/tracker_top.sv
`timescale 1ns/1ps

module tracker_top (
  input wire clk_65mhz,
  input wire sys_rst,
  input tracker_pkg::rgb565_t pixel_in,
  input wire pixel_valid_in,
  input tracker_pkg::hcount_t hcount_in,
  input tracker_pkg::vcount_t vcount_in,
  input wire frame_end_in,
  input tracker_pkg::channel_sel_e channel_sel,
  input tracker_pkg::intensity_t lower_bound,
  input tracker_pkg::intensity_t upper_bound,
  input tracker_pkg::view_mode_e view_mode,
  input wire crosshair_en,
  output tracker_pkg::rgb444_t pixel_out,
  output logic pixel_out_valid,
  output tracker_pkg::hcount_t x_com,
  output tracker_pkg::vcount_t y_com,
  output logic com_valid
);

  // threshold stage outputs, one cycle behind the input
  tracker_pkg::rgb565_t th_pixel;
  logic th_valid;
  tracker_pkg::hcount_t th_hcount;
  tracker_pkg::vcount_t th_vcount;
  tracker_pkg::intensity_t th_intensity;
  logic th_mask;

  channel_threshold threshold_i (
    .clk_65mhz(clk_65mhz),
    .sys_rst(sys_rst),
    .pixel_in(pixel_in),
    .pixel_valid_in(pixel_valid_in),
    .hcount_in(hcount_in),
    .vcount_in(vcount_in),
    .channel_sel(channel_sel),
    .lower_bound(lower_bound),
    .upper_bound(upper_bound),
    .pixel_out(th_pixel),
    .valid_out(th_valid),
    .hcount_out(th_hcount),
    .vcount_out(th_vcount),
    .intensity_out(th_intensity),
    .mask_out(th_mask)
  );

  // frame_end lines up with the last masked pixel here
  center_of_mass com_i (
    .clk_65mhz(clk_65mhz),
    .sys_rst(sys_rst),
    .hcount_in(th_hcount),
    .vcount_in(th_vcount),
    .mask_in(th_mask),
    .frame_end_in(frame_end_in),
    .x_com(x_com),
    .y_com(y_com),
    .com_valid(com_valid)
  );

  view_mux view_i (
    .clk_65mhz(clk_65mhz),
    .sys_rst(sys_rst),
    .pixel_in(th_pixel),
    .valid_in(th_valid),
    .hcount_in(th_hcount),
    .vcount_in(th_vcount),
    .intensity_in(th_intensity),
    .mask_in(th_mask),
    .x_com(x_com),
    .y_com(y_com),
    .view_mode(view_mode),
    .crosshair_en(crosshair_en),
    .pixel_out(pixel_out),
    .pixel_out_valid(pixel_out_valid)
  );

endmodule

//--- logic/view_mux.sv
`timescale 1ns/1ps
`include "tracker_macros.svh"

module view_mux (
  input wire clk_65mhz,
  input wire sys_rst,
  input tracker_pkg::rgb565_t pixel_in,
  input wire valid_in,
  input tracker_pkg::hcount_t hcount_in,
  input tracker_pkg::vcount_t vcount_in,
  input tracker_pkg::intensity_t intensity_in,
  input wire mask_in,
  input tracker_pkg::hcount_t x_com, // held center
  input tracker_pkg::vcount_t y_com,
  input tracker_pkg::view_mode_e view_mode,
  input wire crosshair_en,
  output tracker_pkg::rgb444_t pixel_out,
  output logic pixel_out_valid
);

  tracker_pkg::rgb444_t rgb_pixel; // 565 cut down to 444
  tracker_pkg::rgb444_t mode_pixel;
  logic crosshair; // on the row or column of the center

  assign rgb_pixel = {pixel_in.r[4:1], pixel_in.g[5:2], pixel_in.b[4:1]};
  assign crosshair = crosshair_en && (hcount_in == x_com || vcount_in == y_com);

  always_comb begin
    case (view_mode)
      tracker_pkg::view_gray:      mode_pixel = {intensity_in, intensity_in, intensity_in};
      tracker_pkg::view_mask:      mode_pixel = mask_in ? 12'hFFF : 12'h000;
      tracker_pkg::view_highlight: mode_pixel = mask_in ? `COLOR_PINK : rgb_pixel;
      default:                     mode_pixel = rgb_pixel; // view_rgb
    endcase
  end

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      pixel_out_valid <= 1'b0;
    end else begin
      pixel_out_valid <= valid_in;
    end
  end

  always_ff @(posedge clk_65mhz) begin
    pixel_out <= crosshair ? `COLOR_GREEN : mode_pixel; // crosshair wins in every mode
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the tracker testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_tracker -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_tracker)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1

//--- tb.f
+incdir+common
+incdir+testbench
common/tracker_pkg.sv
logic/channel_threshold.sv
com/seq_divider.sv
com/center_of_mass.sv
logic/view_mux.sv
logic/tracker_top.sv
testbench/tb_tracker.sv

//--- testbench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int check_count = 0; // compares made
int error_count = 0; // compares and other failures

task automatic check_pixel(input string name, input tracker_pkg::rgb444_t got,
                           input tracker_pkg::rgb444_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_hcount(input string name, input tracker_pkg::hcount_t got,
                            input tracker_pkg::hcount_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_vcount(input string name, input tracker_pkg::vcount_t got,
                            input tracker_pkg::vcount_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
  end
endtask

// single status bits such as the valid strobes
task automatic check_flag(input string name, input logic got, input logic exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
  end
endtask

task automatic note_failure(input string what);
  error_count++;
  $display("error at %0t: %s", $time, what);
endtask

task automatic end_test(input string name, input int errors_before);
  if (error_count == errors_before)
    $display("test %s: ok", name);
  else
    $display("test %s: %0d errors", name, error_count - errors_before);
endtask

`endif

//--- testbench/tb_tracker.sv
`timescale 1ns/1ps
`include "tracker_macros.svh"

module tb_tracker;

  localparam int FRAME_W = 32;
  localparam int FRAME_H = 24;
  localparam int FRAME_PIXELS = FRAME_W * FRAME_H;
  localparam int COM_WAIT = 64; // frame_end to com_valid limit
  localparam int NUM_FRAMES = 17; // 9 + 2 + 2 + 4 frames over tests 2 to 5
  // at most one idle slot per pixel, plus config, frame_end and the center wait
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * (2 * FRAME_PIXELS + COM_WAIT + 4) + 100;

  logic clk_65mhz = 1'b0;
  logic sys_rst;
  tracker_pkg::rgb565_t pixel_in;
  logic pixel_valid_in;
  tracker_pkg::hcount_t hcount_in;
  tracker_pkg::vcount_t vcount_in;
  logic frame_end_in;
  tracker_pkg::channel_sel_e channel_sel;
  tracker_pkg::intensity_t lower_bound;
  tracker_pkg::intensity_t upper_bound;
  tracker_pkg::view_mode_e view_mode;
  logic crosshair_en;
  tracker_pkg::rgb444_t pixel_out;
  logic pixel_out_valid;
  tracker_pkg::hcount_t x_com;
  tracker_pkg::vcount_t y_com;
  logic com_valid;

  integer seed = 51030;
  int cycle = 0; // rising edges since time zero
  logic com_window = 1'b0; // com_valid only allowed while set
  tracker_pkg::hcount_t held_x = '0; // model copy of the held center
  tracker_pkg::vcount_t held_y = '0;
  tracker_pkg::rgb444_t exp_q[$]; // expected output pixels, oldest first
  int exp_cycle_q[$]; // cycle each of them was driven
  int out_latency;
  tracker_pkg::view_mode_e all_modes[4] = '{tracker_pkg::view_rgb, tracker_pkg::view_gray,
                                            tracker_pkg::view_mask, tracker_pkg::view_highlight};
  tracker_pkg::channel_sel_e channels[3] = '{tracker_pkg::ch_red, tracker_pkg::ch_green,
                                             tracker_pkg::ch_blue};

  `include "tb_checks.svh"

  tracker_top tracker_top_i (
    .clk_65mhz(clk_65mhz),
    .sys_rst(sys_rst),
    .pixel_in(pixel_in),
    .pixel_valid_in(pixel_valid_in),
    .hcount_in(hcount_in),
    .vcount_in(vcount_in),
    .frame_end_in(frame_end_in),
    .channel_sel(channel_sel),
    .lower_bound(lower_bound),
    .upper_bound(upper_bound),
    .view_mode(view_mode),
    .crosshair_en(crosshair_en),
    .pixel_out(pixel_out),
    .pixel_out_valid(pixel_out_valid),
    .x_com(x_com),
    .y_com(y_com),
    .com_valid(com_valid)
  );

  always #50 clk_65mhz = ~clk_65mhz; // 100 ns period

  always @(posedge clk_65mhz) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("timeout: run still going after %0d cycles", cycle);
      $display("TEST FAIL");
      $finish;
    end
  end

  // outputs are settled by the falling edge
  always @(negedge clk_65mhz) begin
    if (!sys_rst && pixel_out_valid) begin
      if (exp_q.size() == 0) begin
        note_failure("pixel_out_valid high with no pixel expected");
      end else begin
        check_pixel("pixel_out", pixel_out, exp_q.pop_front());
        out_latency = cycle - exp_cycle_q.pop_front();
        if (out_latency != 2)
          note_failure($sformatf("pixel came out %0d cycles after input, not 2", out_latency));
      end
    end
    if (!sys_rst && com_valid && !com_window)
      note_failure("com_valid pulsed when no center update was due");
  end

  task automatic next_cycle();
    @(posedge clk_65mhz);
    #1; // drive just after the edge
  endtask

  // 565 word is r[15:11] g[10:5] b[4:0], intensity is the top nibble of the field
  function automatic tracker_pkg::intensity_t channel_of(input tracker_pkg::rgb565_t p,
                                                         input tracker_pkg::channel_sel_e ch);
    logic [15:0] raw;
    raw = p;
    if (ch == tracker_pkg::ch_green)
      return raw[10:7];
    if (ch == tracker_pkg::ch_blue)
      return raw[4:1];
    return raw[15:12];
  endfunction

  function automatic tracker_pkg::rgb444_t model_pixel(input tracker_pkg::rgb565_t p,
                                                       input tracker_pkg::intensity_t inten,
                                                       input logic masked,
                                                       input tracker_pkg::view_mode_e mode,
                                                       input logic on_cross);
    logic [15:0] raw;
    raw = p;
    if (on_cross)
      return `COLOR_GREEN; // crosshair beats every mode
    case (mode)
      tracker_pkg::view_gray: return {inten, inten, inten};
      tracker_pkg::view_mask: return masked ? 12'hFFF : 12'h000;
      tracker_pkg::view_highlight: if (masked) return `COLOR_PINK;
      default: ;
    endcase
    return {raw[15:12], raw[10:7], raw[4:1]}; // plain rgb
  endfunction

  // random color, about 3 in 8 forced into the band so frames rarely go empty
  function automatic tracker_pkg::rgb565_t random_pixel(input tracker_pkg::channel_sel_e ch,
                                                        input tracker_pkg::intensity_t lo,
                                                        input tracker_pkg::intensity_t hi);
    logic [31:0] r;
    tracker_pkg::rgb565_t p;
    tracker_pkg::intensity_t v;
    int span;
    r = $random(seed);
    p = r[15:0];
    if (r[18:16] < 3'd3 && lo <= hi) begin
      span = int'(hi) - int'(lo) + 1;
      v = 4'(int'(lo) + int'(r[27:20]) % span);
      case (ch)
        tracker_pkg::ch_green: p.g[5:2] = v;
        tracker_pkg::ch_blue: p.b[4:1] = v;
        default: p.r[4:1] = v;
      endcase
    end
    return p;
  endfunction

  task automatic random_bounds(output tracker_pkg::intensity_t lo,
                               output tracker_pkg::intensity_t hi);
    tracker_pkg::intensity_t a;
    tracker_pkg::intensity_t b;
    a = 4'($random(seed));
    b = 4'($random(seed));
    lo = (a < b) ? a : b; // sorted, never an empty band
    hi = (a < b) ? b : a;
  endtask

  task automatic wait_center(input int count, input tracker_pkg::hcount_t exp_x,
                             input tracker_pkg::vcount_t exp_y);
    int n;
    bit seen;
    n = 0;
    seen = 1'b0;
    com_window = (count != 0);
    while (n < COM_WAIT && !seen) begin
      @(negedge clk_65mhz);
      seen = com_valid;
      n++;
    end
    if (count == 0) begin
      if (seen)
        note_failure("com_valid pulsed after a frame with no masked pixels");
    end else if (!seen) begin
      note_failure("com_valid did not pulse within 64 cycles of frame_end");
    end else begin
      held_x = exp_x;
      held_y = exp_y;
      @(negedge clk_65mhz);
      check_flag("com_valid", com_valid, 1'b0); // one cycle only
    end
    check_hcount("x_com", x_com, held_x);
    check_vcount("y_com", y_com, held_y);
    com_window = 1'b0;
  endtask

  task automatic run_frame(input tracker_pkg::view_mode_e mode,
                           input tracker_pkg::channel_sel_e ch,
                           input tracker_pkg::intensity_t lo,
                           input tracker_pkg::intensity_t hi,
                           input logic xhair);
    int h;
    int v;
    int sum_x;
    int sum_y;
    int count;
    logic masked;
    logic on_cross;
    tracker_pkg::rgb565_t p;
    tracker_pkg::intensity_t inten;
    tracker_pkg::hcount_t exp_x;
    tracker_pkg::vcount_t exp_y;
    sum_x = 0;
    sum_y = 0;
    count = 0;
    next_cycle();
    view_mode = mode; // held for the whole frame
    channel_sel = ch;
    lower_bound = lo;
    upper_bound = hi;
    crosshair_en = xhair;
    for (v = 0; v < FRAME_H; v++) begin
      for (h = 0; h < FRAME_W; h++) begin
        if (($random(seed) & 7) == 0) begin
          next_cycle();
          pixel_valid_in = 1'b0; // idle slot with junk on the bus
          pixel_in = 16'($random(seed));
        end
        p = random_pixel(ch, lo, hi);
        inten = channel_of(p, ch);
        masked = (inten >= lo) && (inten <= hi);
        on_cross = xhair && (tracker_pkg::hcount_t'(h) == held_x ||
                             tracker_pkg::vcount_t'(v) == held_y);
        next_cycle();
        pixel_in = p;
        pixel_valid_in = 1'b1;
        hcount_in = tracker_pkg::hcount_t'(h);
        vcount_in = tracker_pkg::vcount_t'(v);
        exp_q.push_back(model_pixel(p, inten, masked, mode, on_cross));
        exp_cycle_q.push_back(cycle);
        if (masked) begin
          sum_x += h;
          sum_y += v;
          count++;
        end
      end
    end
    next_cycle();
    pixel_valid_in = 1'b0;
    frame_end_in = 1'b1; // meets the last pixel after the threshold stage
    next_cycle();
    frame_end_in = 1'b0;
    exp_x = held_x;
    exp_y = held_y;
    if (count != 0) begin
      exp_x = tracker_pkg::hcount_t'(sum_x / count); // floor mean
      exp_y = tracker_pkg::vcount_t'(sum_y / count);
    end
    wait_center(count, exp_x, exp_y);
    if (exp_q.size() != 0)
      note_failure("expected pixels never came out of the DUT");
  endtask

  initial begin
    int mi;
    int ci;
    int test_errors;
    tracker_pkg::intensity_t lo;
    tracker_pkg::intensity_t hi;
    sys_rst = 1'b1;
    pixel_in = '0;
    pixel_valid_in = 1'b1; // stream keeps running into reset, nothing may come out
    hcount_in = '0;
    vcount_in = '0;
    frame_end_in = 1'b0;
    channel_sel = tracker_pkg::ch_red;
    lower_bound = '0;
    upper_bound = '0;
    view_mode = tracker_pkg::view_rgb;
    crosshair_en = 1'b0;
    repeat (10) @(posedge clk_65mhz);
    #1;
    sys_rst = 1'b0;
    pixel_valid_in = 1'b0;

    test_errors = error_count;
    @(negedge clk_65mhz);
    check_flag("pixel_out_valid", pixel_out_valid, 1'b0);
    check_flag("com_valid", com_valid, 1'b0);
    check_hcount("x_com", x_com, '0);
    check_vcount("y_com", y_com, '0);
    end_test("1 reset values", test_errors);

    test_errors = error_count;
    for (mi = 0; mi < 3; mi++) begin
      for (ci = 0; ci < 3; ci++) begin
        random_bounds(lo, hi);
        run_frame(all_modes[mi], channels[ci], lo, hi, 1'b0);
      end
    end
    end_test("2 rgb, gray and mask views", test_errors);

    test_errors = error_count;
    for (ci = 0; ci < 2; ci++) begin
      random_bounds(lo, hi);
      run_frame(tracker_pkg::view_highlight, channels[ci], lo, hi, 1'b0);
    end
    end_test("3 highlight view", test_errors);

    test_errors = error_count;
    run_frame(tracker_pkg::view_rgb, tracker_pkg::ch_green, 4'd2, 4'd13, 1'b0);
    run_frame(tracker_pkg::view_mask, tracker_pkg::ch_red, 4'd9, 4'd4, 1'b0); // empty band
    end_test("4 center of mass and empty frame", test_errors);

    test_errors = error_count;
    for (mi = 0; mi < 4; mi++) begin
      random_bounds(lo, hi);
      run_frame(all_modes[mi], channels[mi % 3], lo, hi, 1'b1);
    end
    end_test("5 crosshair in every view", test_errors);

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule
